//--- common/fb_scale_config.svh
/* Scaled framebuffer overlay
   Widths, memory sizes and CPU register offsets */
`ifndef FB_SCALE_CONFIG_SVH
`define FB_SCALE_CONFIG_SVH

`define FB_COORD_W      9     // Window and source coordinates
`define FB_ADDR_W       16    // Texture memory word address
`define FB_ACC_W        12    // DDA accumulators and gradients
`define FB_DATA_W       16
`define FB_TEXEL_W      8
`define FB_COLOR_W      16    // ARGB 4:4:4:4
`define FB_DISP_W       10    // Raster x and y counters
`define FB_PAL_DEPTH    256
`define FB_LINE_DEPTH   512

`define FB_REG_CTRL     4'd0
`define FB_REG_X1       4'd1
`define FB_REG_Y1       4'd2
`define FB_REG_X2       4'd3
`define FB_REG_Y2       4'd4
`define FB_REG_U1       4'd5
`define FB_REG_V1       4'd6
`define FB_REG_U2       4'd7
`define FB_REG_V2       4'd8
`define FB_REG_STRIDE   4'd9
`define FB_REG_BASE     4'd10
`define FB_REG_V1_MULT  4'd11

`endif

//--- common/fb_scale_pkg.sv
/* Scaled framebuffer overlay
   Shared types for registers, raster position, line writes and the render FSM */
`default_nettype none
`include "fb_scale_config.svh"

package fb_scale_pkg;

	typedef logic [`FB_COORD_W-1:0] coord_t;
	typedef logic [`FB_ADDR_W-1:0]  mem_addr_t;
	typedef logic [`FB_ACC_W-1:0]   acc_t;
	typedef logic [`FB_TEXEL_W-1:0] texel_t;   // Palette index
	typedef logic [`FB_COLOR_W-1:0] color_t;

	// Register image seen by render and scanout
	typedef struct packed {
		logic      enable;
		coord_t    x1;
		coord_t    y1;
		coord_t    x2;
		coord_t    y2;
		coord_t    u1;
		coord_t    v1;
		coord_t    u2;
		coord_t    v2;
		coord_t    stride;
		mem_addr_t base;
		mem_addr_t v1_mult;   // v1 already multiplied by stride
	} fb_cfg_t;

	typedef struct packed {
		logic [$clog2(`FB_PAL_DEPTH)-1:0] address;
		logic [`FB_DATA_W-1:0]            data;
		logic                             wr_reg;
		logic                             wr_pal;
	} cpu_wr_t;

	typedef struct packed {
		logic [`FB_DISP_W-1:0] x;
		logic [`FB_DISP_W-1:0] y;
		logic                  h_tick;   // Horizontal count is zero
		logic                  v_tick;   // Vertical count is zero
		logic                  re;       // Visible area
	} disp_pos_t;

	typedef struct packed {
		logic   we;
		logic   sel;    // Target scanline buffer
		coord_t addr;
		texel_t data;
	} line_wr_t;

	typedef enum logic [2:0] {
		IDLE,
		BEGIN,
		FETCH,
		BLIT,
		ADJUST_X,
		UPDATE_Y,
		ADJUST_Y,
		WAIT_LINE
	} render_state_t;

endpackage

`default_nettype wire

//--- rtl/dp_ram.sv
/* Simple dual-port block RAM
   One write port, one read port with registered output */
`timescale 1ns/1ps
`default_nettype none

module dp_ram #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 512
) (
	input  wire logic                     CLK,
	input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
	output logic      [WIDTH-1:0]         rd_data,
	input  wire logic                     wr_en,
	input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
	input  wire logic [WIDTH-1:0]         wr_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Read returns old contents on a same-address write
	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- fb_scale/fb_scale_regs.sv
/* Framebuffer overlay register file
   Decodes CPU writes into the window and texture configuration */
`timescale 1ns/1ps
`default_nettype none
`include "fb_scale_config.svh"

module fb_scale_regs (
	input  wire logic                  CLK,
	input  wire logic                  RSTb,
	input  wire fb_scale_pkg::cpu_wr_t cpu,
	output fb_scale_pkg::fb_cfg_t      cfg
);

	// Palette writes are picked up by the scanout
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cfg <= '0;
		end else if (cpu.wr_reg) begin
			case (cpu.address[3:0])
				`FB_REG_CTRL:
					cfg.enable <= cpu.data[0];
				`FB_REG_X1:
					cfg.x1 <= cpu.data[`FB_COORD_W-1:0];
				`FB_REG_Y1:
					cfg.y1 <= cpu.data[`FB_COORD_W-1:0];
				`FB_REG_X2:
					cfg.x2 <= cpu.data[`FB_COORD_W-1:0];
				`FB_REG_Y2:
					cfg.y2 <= cpu.data[`FB_COORD_W-1:0];
				`FB_REG_U1:
					cfg.u1 <= cpu.data[`FB_COORD_W-1:0];
				`FB_REG_V1:
					cfg.v1 <= cpu.data[`FB_COORD_W-1:0];
				`FB_REG_U2:
					cfg.u2 <= cpu.data[`FB_COORD_W-1:0];
				`FB_REG_V2:
					cfg.v2 <= cpu.data[`FB_COORD_W-1:0];
				`FB_REG_STRIDE:
					cfg.stride <= cpu.data[`FB_COORD_W-1:0];   // Texture width in bytes
				`FB_REG_BASE:
					cfg.base <= cpu.data[`FB_ADDR_W-1:0];     // Word address
				`FB_REG_V1_MULT:
					cfg.v1_mult <= cpu.data[`FB_ADDR_W-1:0];
				default: ;   // Unused offsets
			endcase
		end
	end

endmodule

`default_nettype wire

//--- fb_scale/fb_scale_render.sv
/* Framebuffer overlay render engine
   Fetches texels, scales and flips them with a DDA, fills the back scanline buffer */
`timescale 1ns/1ps
`default_nettype none
`include "fb_scale_config.svh"

module fb_scale_render (
	input  wire logic                    CLK,
	input  wire logic                    RSTb,
	input  wire fb_scale_pkg::fb_cfg_t   cfg,
	input  wire fb_scale_pkg::disp_pos_t disp,
	output logic                         mem_req,
	output fb_scale_pkg::mem_addr_t      mem_addr,
	input  wire logic [`FB_DATA_W-1:0]   mem_data,
	input  wire logic                    mem_ack,
	output fb_scale_pkg::line_wr_t       line_wr,
	output logic                         front_sel,
	output logic                         front_valid
);

	import fb_scale_pkg::*;

	localparam int BA_W = `FB_ADDR_W + 1;   // Byte address

	render_state_t   state;
	render_state_t   state_nxt;
	logic [BA_W-1:0] cur_addr;
	logic [BA_W-1:0] row_addr;
	logic [BA_W-1:0] row_start;
	logic [BA_W-1:0] x_step;
	logic [BA_W-1:0] y_step;
	acc_t            du;
	acc_t            dv;
	acc_t            dx;
	acc_t            dy;
	acc_t            accu_u;
	acc_t            accu_v;
	coord_t          x;
	coord_t          pair;
	texel_t          texel;
	logic            wr_stb;
	logic            pair_cnt;
	logic            back_full;   // Finished row waiting for a swap
	logic            start;
	logic            swap;
	logic            x_more;
	logic            y_more;

	assign pair = disp.y[`FB_DISP_W-1:1];
	assign row_start = {cfg.base, 1'b0} + BA_W'(cfg.u1) + {cfg.v1_mult, 1'b0};

	// Only the first line of a pair may start a frame
	assign start = (state == IDLE) && disp.h_tick && cfg.enable && !disp.y[0] &&
		(pair >= cfg.y1) && (pair <= cfg.y2);
	assign swap = disp.h_tick && pair_cnt &&
		((state == WAIT_LINE) || ((state == IDLE) && (back_full || front_valid)));

	// A zero span never steps
	assign x_more = (dx != '0) && (accu_u >= dx);
	assign y_more = (dy != '0) && (accu_v >= dy);

	assign mem_req = (state == FETCH);
	assign mem_addr = cur_addr[BA_W-1:1];
	assign line_wr = '{we: wr_stb, sel: ~front_sel, addr: x, data: texel};

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:      if (start) state_nxt = BEGIN;
			BEGIN:     state_nxt = FETCH;
			FETCH:     if (mem_ack) state_nxt = BLIT;
			BLIT:      state_nxt = ADJUST_X;
			ADJUST_X:  if (!x_more) state_nxt = (x >= cfg.x2) ? UPDATE_Y : FETCH;
			UPDATE_Y:  state_nxt = ADJUST_Y;
			ADJUST_Y:  if (!y_more) state_nxt = (pair >= cfg.y2) ? IDLE : WAIT_LINE;
			WAIT_LINE: if (swap) state_nxt = FETCH;
			default:   state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state       <= IDLE;
			pair_cnt    <= 1'b0;
			back_full   <= 1'b0;
			front_sel   <= 1'b0;
			front_valid <= 1'b0;
			wr_stb      <= 1'b0;
		end else begin
			state  <= state_nxt;
			wr_stb <= (state == FETCH) && mem_ack;   // Write lands in BLIT
			if (disp.h_tick)
				pair_cnt <= start ? 1'b0 : ~pair_cnt;
			if (swap) begin
				front_sel   <= ~front_sel;
				front_valid <= back_full;   // Empty swap after the last row
				back_full   <= 1'b0;
			end else if ((state == ADJUST_Y) && !y_more) begin
				back_full <= 1'b1;
			end
		end
	end

	// DDA datapath
	always_ff @(posedge CLK) begin
		case (state)
			BEGIN: begin
				accu_u   <= '0;
				accu_v   <= '0;
				dx       <= acc_t'(cfg.x2) - acc_t'(cfg.x1);
				dy       <= acc_t'(cfg.y2) - acc_t'(cfg.y1);
				x        <= cfg.x1;
				cur_addr <= row_start;
				row_addr <= row_start;
				if (cfg.u1 > cfg.u2) begin   // Horizontal flip
					du     <= acc_t'(cfg.u1) - acc_t'(cfg.u2);
					x_step <= '1;
				end else begin
					du     <= acc_t'(cfg.u2) - acc_t'(cfg.u1);
					x_step <= BA_W'(1);
				end
				if (cfg.v1 > cfg.v2) begin   // Vertical flip
					dv     <= acc_t'(cfg.v1) - acc_t'(cfg.v2);
					y_step <= -BA_W'(cfg.stride);
				end else begin
					dv     <= acc_t'(cfg.v2) - acc_t'(cfg.v1);
					y_step <= BA_W'(cfg.stride);
				end
			end
			FETCH:
				if (mem_ack)
					texel <= cur_addr[0] ? mem_data[15:8] : mem_data[7:0];
			BLIT:
				accu_u <= accu_u + du;
			ADJUST_X: begin
				if (x_more) begin
					accu_u   <= accu_u - dx;
					cur_addr <= cur_addr + x_step;
				end else if (x < cfg.x2) begin
					x <= x + 1'b1;
				end
			end
			UPDATE_Y: begin
				accu_u <= '0;
				accu_v <= accu_v + dv;
				x      <= cfg.x1;
			end
			ADJUST_Y: begin
				if (y_more) begin
					accu_v   <= accu_v - dy;
					row_addr <= row_addr + y_step;
				end else begin
					cur_addr <= row_addr;   // Start of the next source row
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- fb_scale/fb_scale_scanout.sv
/* Framebuffer overlay scanout
   Reads the front scanline buffer at half resolution, masks it and looks up the palette */
`timescale 1ns/1ps
`default_nettype none
`include "fb_scale_config.svh"

module fb_scale_scanout (
	input  wire logic                    CLK,
	input  wire fb_scale_pkg::fb_cfg_t   cfg,
	input  wire fb_scale_pkg::cpu_wr_t   cpu,
	input  wire fb_scale_pkg::disp_pos_t disp,
	input  wire fb_scale_pkg::line_wr_t  line_wr,
	input  wire logic                    front_sel,
	input  wire logic                    front_valid,
	output fb_scale_pkg::color_t         color
);

	import fb_scale_pkg::*;

	texel_t                 line_rd [2];
	texel_t                 pal_idx;
	coord_t                 pix_x;
	logic [`FB_COORD_W:0]   pair;   // One bit wider for the y2+1 bound
	logic [`FB_COORD_W:0]   row_lo;
	logic [`FB_COORD_W:0]   row_hi;
	logic                   in_win;
	logic                   win_q;

	assign pix_x = disp.x[`FB_DISP_W-1:1];
	assign pair = {1'b0, disp.y[`FB_DISP_W-1:1]};
	assign row_lo = {1'b0, cfg.y1} + 1'b1;   // Rows show one pair late
	assign row_hi = {1'b0, cfg.y2} + 1'b1;

	assign in_win = cfg.enable && disp.re &&
		(pix_x >= cfg.x1) && (pix_x <= cfg.x2) && (pair >= row_lo) && (pair <= row_hi);

	for (genvar i = 0; i < 2; i++) begin : g_line
		dp_ram #(.WIDTH(`FB_TEXEL_W), .DEPTH(`FB_LINE_DEPTH)) line_buf_i (
			.CLK     (CLK),
			.rd_addr (pix_x),
			.rd_data (line_rd[i]),
			.wr_en   (line_wr.we && (line_wr.sel == i[0])),
			.wr_addr (line_wr.addr),
			.wr_data (line_wr.data)
		);
	end

	always_ff @(posedge CLK)
		win_q <= in_win;

	// Buffer select taken after the read so a swap at h_tick covers pixel 0
	assign pal_idx = (win_q && front_valid) ? line_rd[front_sel] : '0;

	dp_ram #(.WIDTH(`FB_COLOR_W), .DEPTH(`FB_PAL_DEPTH)) palette_i (
		.CLK     (CLK),
		.rd_addr (pal_idx),
		.rd_data (color),
		.wr_en   (cpu.wr_pal),
		.wr_addr (cpu.address),
		.wr_data (cpu.data)
	);

endmodule

`default_nettype wire

//--- rtl/fb_scale_top.sv
/* Scaled framebuffer overlay
   Register file, render engine and scanout */
`timescale 1ns/1ps
`default_nettype none
`include "fb_scale_config.svh"

module fb_scale_top (
	input  wire logic                    CLK,
	input  wire logic                    RSTb,
	input  wire fb_scale_pkg::cpu_wr_t   cpu,
	input  wire fb_scale_pkg::disp_pos_t disp,
	output fb_scale_pkg::color_t         color,
	output logic                         mem_req,
	output fb_scale_pkg::mem_addr_t      mem_addr,
	input  wire logic [`FB_DATA_W-1:0]   mem_data,
	input  wire logic                    mem_ack
);

	import fb_scale_pkg::*;

	fb_cfg_t  cfg;
	line_wr_t line_wr;
	logic     front_sel;
	logic     front_valid;

	fb_scale_regs regs_i (
		.CLK  (CLK),
		.RSTb (RSTb),
		.cpu  (cpu),
		.cfg  (cfg)
	);

	fb_scale_render render_i (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.cfg         (cfg),
		.disp        (disp),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.mem_ack     (mem_ack),
		.line_wr     (line_wr),
		.front_sel   (front_sel),
		.front_valid (front_valid)
	);

	fb_scale_scanout scanout_i (
		.CLK         (CLK),
		.cfg         (cfg),
		.cpu         (cpu),
		.disp        (disp),
		.line_wr     (line_wr),
		.front_sel   (front_sel),
		.front_valid (front_valid),
		.color       (color)
	);

endmodule

`default_nettype wire

//--- testbench/tb_fb_memory.sv
/* Texture memory model for the overlay testbench
   Random contents, answers each request after 1 to 3 cycles */
`timescale 1ns/1ps
`default_nettype none

module tb_fb_memory #(
	parameter int SEED = 1
) (
	input  wire logic        CLK,
	input  wire logic        RSTb,
	input  wire logic        req,
	input  wire logic [15:0] addr,
	output logic      [15:0] data,
	output logic             ack
);

	logic [15:0] mem [65536];
	integer      seed;
	int          wait_cnt;
	logic        busy;   // Request seen, delay running

	initial begin
		seed     = SEED;
		ack      = 1'b0;
		data     = '0;
		busy     = 1'b0;
		wait_cnt = 0;
		for (int i = 0; i < 65536; i++)
			mem[i] = 16'($random(seed));
	end

	always @(posedge CLK) begin
		#1;
		if (!RSTb || ack) begin
			ack  = 1'b0;   // Single-cycle ack
			busy = 1'b0;
		end else if (req) begin
			if (!busy) begin
				busy     = 1'b1;
				wait_cnt = int'($unsigned($random(seed)) % 3);
			end else if (wait_cnt == 0) begin
				ack  = 1'b1;
				data = mem[addr];
			end else begin
				wait_cnt--;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_fb_scale.sv
/* Testbench for the scaled framebuffer overlay
   Raster generator, CPU writes, reference model of rendering and display */
`timescale 1ns/1ps
`default_nettype none
`include "fb_scale_config.svh"

module tb_fb_scale;

	import fb_scale_pkg::*;

	localparam int LINE_CYC   = 200;
	localparam int VIS_PIX    = 64;
	localparam int LINES      = 40;
	localparam int FRAME_CYC  = LINE_CYC * LINES;
	localparam int NUM_FRAMES = 11;
	localparam int TIMEOUT    = NUM_FRAMES * FRAME_CYC + 1000;
	localparam int STRIDE     = 64;       // Texture row in bytes
	localparam int BASE       = 'h400;    // Word address

	logic      CLK = 1'b0;
	logic      RSTb;
	cpu_wr_t   cpu;
	disp_pos_t disp;
	color_t    color;
	logic      mem_req;
	mem_addr_t mem_addr;
	logic [15:0] mem_data;
	logic      mem_ack;

	integer seed;
	int     errors;
	int     cycles;
	int     hx;
	int     vy;
	bit     checking;
	color_t pal [256];
	texel_t img [32][32];   // Expected destination rows
	bit     en;
	int     x1, y1, x2, y2, u1, v1, u2, v2;
	color_t exp_q [$];
	bit     chk_q [$];

	always #2 CLK = ~CLK;

	fb_scale_top dut_i (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.cpu      (cpu),
		.disp     (disp),
		.color    (color),
		.mem_req  (mem_req),
		.mem_addr (mem_addr),
		.mem_data (mem_data),
		.mem_ack  (mem_ack)
	);

	tb_fb_memory #(.SEED(65689)) mem_i (
		.CLK  (CLK),
		.RSTb (RSTb),
		.req  (mem_req),
		.addr (mem_addr),
		.data (mem_data),
		.ack  (mem_ack)
	);

	always @(posedge CLK) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic texel_t texel_at(input int byte_addr);
		logic [15:0] w;
		w = mem_i.mem[(byte_addr >> 1) & 'hffff];
		return (byte_addr & 1) ? w[15:8] : w[7:0];
	endfunction

	// Each source row and column stepped by the DDA rule
	task automatic build_image();
		int addr, row, au, av, du, dv, dx, dy, xs, ys;
		dx  = x2 - x1;
		dy  = y2 - y1;
		du  = (u1 > u2) ? u1 - u2 : u2 - u1;
		dv  = (v1 > v2) ? v1 - v2 : v2 - v1;
		xs  = (u1 > u2) ? -1 : 1;
		ys  = (v1 > v2) ? -STRIDE : STRIDE;
		row = BASE * 2 + u1 + v1 * STRIDE;
		av  = 0;
		for (int r = 0; r <= dy; r++) begin
			addr = row;
			au   = 0;
			for (int c = 0; c <= dx; c++) begin
				img[r][c] = texel_at(addr);
				au += du;
				while (dx != 0 && au >= dx) begin
					au   -= dx;
					addr += xs;
				end
			end
			av += dv;
			while (dy != 0 && av >= dy) begin
				av  -= dy;
				row += ys;
			end
		end
	endtask

	function automatic color_t predict(input int px_raw, input int line);
		int     px, p;
		texel_t idx;
		px  = px_raw / 2;
		p   = line / 2;
		idx = '0;
		if (en && px_raw < VIS_PIX && px >= x1 && px <= x2 && p >= y1 + 1 && p <= y2 + 1)
			idx = img[p - 1 - y1][px - x1];   // Row shown one pair late
		return pal[idx];
	endfunction

	// Check the color from two cycles ago and drive the next position
	task automatic tick(input cpu_wr_t w);
		color_t expc;
		bit     chk;
		@(posedge CLK);
		#1;
		if (exp_q.size() == 2) begin
			expc = exp_q.pop_front();
			chk  = chk_q.pop_front();
			if (chk && color !== expc) begin
				$display("CHECK FAILED t=%0t color expected %h actual %h", $time, expc, color);
				errors++;
			end
		end
		if (!en && mem_req) begin
			$display("Memory request at %0t while the overlay is disabled", $time);
			errors++;
		end
		cpu         = w;
		disp.x      = 10'(hx);
		disp.y      = 10'(vy);
		disp.h_tick = (hx == 0);
		disp.v_tick = (hx == 0) && (vy == 0);
		disp.re     = (hx < VIS_PIX);
		if (w.wr_pal)
			pal[w.address] = w.data;
		exp_q.push_back(predict(hx, vy));
		chk_q.push_back(checking);
		hx++;
		if (hx == LINE_CYC) begin
			hx = 0;
			vy = (vy == LINES - 1) ? 0 : vy + 1;
		end
	endtask

	task automatic write_reg(input logic [3:0] a, input int d);
		cpu_wr_t w;
		w         = '0;
		w.address = {4'h0, a};
		w.data    = d[15:0];
		w.wr_reg  = 1'b1;
		tick(w);
	endtask

	task automatic write_pal(input int a);
		cpu_wr_t w;
		w         = '0;
		w.address = a[7:0];
		w.data    = 16'($random(seed));
		w.wr_pal  = 1'b1;
		tick(w);
	endtask

	task automatic finish_frame();
		do
			tick('0);
		while (!(hx == 0 && vy == 0));
	endtask

	// Configure in the first line pair, then show one full frame
	task automatic run_case(input bit e, input int nx1, input int ny1, input int nx2,
		input int ny2, input int nu1, input int nv1, input int nu2, input int nv2);
		x1 = nx1;
		y1 = ny1;
		x2 = nx2;
		y2 = ny2;
		u1 = nu1;
		v1 = nv1;
		u2 = nu2;
		v2 = nv2;
		build_image();
		write_reg(`FB_REG_CTRL, 0);
		write_reg(`FB_REG_X1, x1);
		write_reg(`FB_REG_Y1, y1);
		write_reg(`FB_REG_X2, x2);
		write_reg(`FB_REG_Y2, y2);
		write_reg(`FB_REG_U1, u1);
		write_reg(`FB_REG_V1, v1);
		write_reg(`FB_REG_U2, u2);
		write_reg(`FB_REG_V2, v2);
		write_reg(`FB_REG_STRIDE, STRIDE);
		write_reg(`FB_REG_BASE, BASE);
		write_reg(`FB_REG_V1_MULT, v1 * STRIDE / 2);
		write_reg(`FB_REG_CTRL, e);
		en = e;
		finish_frame();
	endtask

	initial begin
		seed     = 65689;
		errors   = 0;
		cycles   = 0;
		hx       = 0;
		vy       = 0;
		checking = 0;
		en       = 0;
		cpu  = '0;
		disp = '0;
		RSTb = 1'b0;
		repeat (8) @(posedge CLK);
		#1 RSTb = 1'b1;

		// Reset state with a full palette and the overlay off
		for (int i = 0; i < 256; i++)
			write_pal(i);
		checking = 1;
		finish_frame();

		run_case(1, 4, 2, 19, 9, 3, 5, 18, 12);       // Unscaled copy
		run_case(1, 1, 2, 31, 16, 10, 3, 25, 10);     // Twice the source span
		run_case(1, 5, 3, 14, 8, 0, 0, 18, 10);       // Half the source span
		run_case(1, 2, 2, 22, 12, 40, 4, 20, 14);     // Horizontal mirror
		run_case(1, 3, 2, 20, 14, 6, 20, 23, 8);      // Vertical mirror

		// New palette entries on the same image
		for (int i = 0; i < 16; i++)
			write_pal((i == 0) ? 0 : rand_range(1, 255));
		finish_frame();

		repeat (3) begin
			x1 = rand_range(0, 15);
			y1 = rand_range(1, 8);
			run_case(1, x1, y1, rand_range(x1, 31), rand_range(y1, 17),
				rand_range(0, 63), rand_range(0, 40), rand_range(0, 63), rand_range(0, 40));
		end
		run_case(0, 4, 2, 19, 9, 3, 5, 18, 12);

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/fb_scale_pkg.sv
rtl/dp_ram.sv
fb_scale/fb_scale_regs.sv
fb_scale/fb_scale_render.sv
fb_scale/fb_scale_scanout.sv
rtl/fb_scale_top.sv
testbench/tb_fb_memory.sv
testbench/tb_fb_scale.sv

//--- Makefile
# Verilator flow for the scaled framebuffer overlay

VERILATOR ?= verilator
TOP       ?= tb_fb_scale
RTL_TOP   ?= fb_scale_top
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
